//--- compile.f
logic/axi_wr_pkg.sv
logic/sync_fifo.sv
logic/burst_addr_gen.sv
logic/wr_burst_ctrl.sv
logic/axi_slave_wr.sv
test/axi_slave_wr_properties.sv
test/tb_axi_slave_wr.sv

//--- logic/axi_slave_wr.sv
// AXI4 write-channel slave top level
// AW, W and B buffers around the burst controller

`timescale 1ns/1ps
`default_nettype none

module axi_slave_wr (
    input  logic                 clk,
    input  logic                 rst_n,
    // AW channel
    input  axi_wr_pkg::aw_req_t  aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    // W channel
    input  axi_wr_pkg::w_beat_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    // B channel
    output axi_wr_pkg::b_resp_t  b,
    output logic                 b_valid,
    input  logic                 b_ready,
    // Memory write port and arbiter handshake
    input  logic                 wr_grant,
    output logic                 wr_request,
    output logic                 mem_we,
    output axi_wr_pkg::mem_wr_t  mem
);

    import axi_wr_pkg::*;

    // ------------------------------------------------------------------
    // Buffer status and heads
    // ------------------------------------------------------------------
    logic    aw_full;
    logic    aw_empty;
    logic    aw_pop;
    aw_req_t aw_head;

    logic    w_full;
    logic    w_empty;
    logic    w_pop;
    w_beat_t w_head;

    logic    b_full;
    logic    b_empty;
    logic    b_push;
    b_resp_t b_din;

    // AXI handshakes map directly onto buffer flags
    assign aw_ready = !aw_full;
    assign w_ready  = !w_full;
    assign b_valid  = !b_empty;

    // ------------------------------------------------------------------
    // Channel buffers
    // ------------------------------------------------------------------
    sync_fifo #(.payload_t(aw_req_t), .DEPTH(AW_DEPTH)) u_aw_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (aw_valid && aw_ready),
        .din   (aw),
        .pop   (aw_pop),
        .q     (aw_head),
        .full  (aw_full),
        .empty (aw_empty)
    );

    sync_fifo #(.payload_t(w_beat_t), .DEPTH(W_DEPTH)) u_w_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (w_valid && w_ready),
        .din   (w),
        .pop   (w_pop),
        .q     (w_head),
        .full  (w_full),
        .empty (w_empty)
    );

    sync_fifo #(.payload_t(b_resp_t), .DEPTH(B_DEPTH)) u_b_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (b_push),
        .din   (b_din),
        .pop   (b_valid && b_ready),
        .q     (b),
        .full  (b_full),
        .empty (b_empty)
    );

    // Burst controller
    wr_burst_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .aw_head    (aw_head),
        .aw_empty   (aw_empty),
        .aw_pop     (aw_pop),
        .w_head     (w_head),
        .w_empty    (w_empty),
        .w_pop      (w_pop),
        .b_push     (b_push),
        .b_din      (b_din),
        .b_full     (b_full),
        .wr_grant   (wr_grant),
        .wr_request (wr_request),
        .mem_we     (mem_we),
        .mem        (mem)
    );

endmodule

`default_nettype wire

//--- logic/axi_wr_pkg.sv
// Shared widths, buffer depths and protocol codes for the AXI4 write slave
// Channel payload structs for AW, W, B and the local memory write port

`default_nettype none

package axi_wr_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------

    // Data bus and its byte lanes
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;

    // Address and ID
    localparam int ADDR_W   = 32;
    localparam int ID_W     = 4;

    // AWLEN and AWSIZE field widths
    localparam int LEN_W    = 8;
    localparam int SIZE_W   = 3;

    // Widest legal transfer, log2 of bytes per data word
    localparam logic [SIZE_W-1:0] MAX_SIZE = SIZE_W'(2);

    // Bursts may not leave a 4 KB page
    localparam int PAGE_W   = 12;

    // ------------------------------------------------------------------
    // Buffer depths
    // ------------------------------------------------------------------

    localparam int AW_DEPTH = 4;
    localparam int W_DEPTH  = 16;
    localparam int B_DEPTH  = 4;

    // ------------------------------------------------------------------
    // Protocol encodings
    // ------------------------------------------------------------------

    // AWBURST, WRAP and reserved codes fall through to INCR handling
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    // BRESP
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ------------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------------

    // One write burst header as seen on AW
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        logic [1:0]        burst;
    } aw_req_t;

    // One write data beat as seen on W
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    // Write response
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } b_resp_t;

    // Beat toward the local memory, address already resolved
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } mem_wr_t;

endpackage

`default_nettype wire

//--- logic/burst_addr_gen.sv
// Beat address generator for FIXED and INCR write bursts
// Aligns the start address, steps by the transfer size, holds at 4 KB edges

`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen (
    input  axi_wr_pkg::aw_req_t            hdr,
    input  logic [axi_wr_pkg::ADDR_W-1:0]  cur_addr,
    output logic [axi_wr_pkg::ADDR_W-1:0]  first_addr,
    output logic [axi_wr_pkg::ADDR_W-1:0]  next_addr
);

    import axi_wr_pkg::*;

    // Transfer size clipped to the bus width
    logic [SIZE_W-1:0] eff_size;

    // Alignment mask and per-beat step
    logic [ADDR_W-1:0] size_mask;
    logic [ADDR_W-1:0] addr_inc;

    // Base of the step and the raw stepped address
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] step_addr;

    // Stepped address lands in another 4 KB page
    logic              page_cross;

    // First beat goes out exactly as requested
    assign first_addr = hdr.addr;

    // ------------------------------------------------------------------
    // Size handling
    // ------------------------------------------------------------------

    // Oversized transfers are stepped as full words, the response flags them
    assign eff_size  = (hdr.size > MAX_SIZE) ? MAX_SIZE : hdr.size;
    assign size_mask = {ADDR_W{1'b1}} << eff_size;

    // FIXED stays put, everything else advances by one transfer
    assign addr_inc  = (hdr.burst == BURST_FIXED) ? '0 : (ADDR_W'(1) << eff_size);

    // ------------------------------------------------------------------
    // Next address
    // ------------------------------------------------------------------

    // On the first beat cur_addr is the raw start address, so aligning it
    // gives the aligned start; later beats are already aligned
    assign base_addr = cur_addr & size_mask;
    assign step_addr = base_addr + addr_inc;

    // Compare the page bits, wrap at the top of the space also counts
    assign page_cross = (step_addr[ADDR_W-1:PAGE_W] != base_addr[ADDR_W-1:PAGE_W]);

    always_comb begin
        if (page_cross) begin
            // Stay on the last in-page address
            next_addr = base_addr;
        end else begin
            next_addr = step_addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/sync_fifo.sv
// Show-ahead synchronous FIFO, payload type set by parameter
// Head of queue is presented on q whenever the FIFO holds data

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t q,
    output logic     full,
    output logic     empty
);

    // Pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage array
    payload_t         mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Qualified strobes, a push into a full buffer is dropped
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Status flags from the occupancy count
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Show-ahead, head read straight from the array
    assign q = mem[rd_ptr];

    // ------------------------------------------------------------------
    // Storage write
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // ------------------------------------------------------------------
    // Pointers and count
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap at DEPTH so non power of two depths also work
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/wr_burst_ctrl.sv
// Write burst controller: phase FSM, header latch, beat counter
// Drives the memory write port and pushes B responses

`timescale 1ns/1ps
`default_nettype none

module wr_burst_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  axi_wr_pkg::aw_req_t  aw_head,
    input  logic                 aw_empty,
    output logic                 aw_pop,
    input  axi_wr_pkg::w_beat_t  w_head,
    input  logic                 w_empty,
    output logic                 w_pop,
    output logic                 b_push,
    output axi_wr_pkg::b_resp_t  b_din,
    input  logic                 b_full,
    input  logic                 wr_grant,
    output logic                 wr_request,
    output logic                 mem_we,
    output axi_wr_pkg::mem_wr_t  mem
);

    import axi_wr_pkg::*;

    // FIRST issues beat one, BURST the rest, BRESP waits for B room
    typedef enum logic [1:0] {PH_IDLE, PH_FIRST, PH_BURST, PH_BRESP} phase_t;

    phase_t            phase;
    phase_t            phase_nxt;

    // Header latched on the first beat, and the one in use this cycle
    aw_req_t           hdr_q;
    aw_req_t           cur_hdr;

    // Beat bookkeeping
    logic [LEN_W-1:0]  beat_cnt;
    logic [ADDR_W-1:0] beat_addr;
    logic [ADDR_W-1:0] first_addr;
    logic [ADDR_W-1:0] next_addr;
    logic              beat_ok;
    logic              last_beat;

    // ------------------------------------------------------------------
    // Beat issue
    // ------------------------------------------------------------------

    // In FIRST the header still sits at the AW head
    assign cur_hdr = (phase == PH_FIRST) ? aw_head : hdr_q;

    // Ready to issue, independent of the grant
    assign wr_request = ((phase == PH_FIRST) && !aw_empty && !w_empty) ||
                        ((phase == PH_BURST) && !w_empty);
    assign beat_ok    = wr_request && wr_grant;

    assign mem_we = beat_ok;
    assign w_pop  = beat_ok;
    assign aw_pop = beat_ok && (phase == PH_FIRST);

    // Burst end by count, not by WLAST
    assign last_beat = (phase == PH_FIRST) ? (aw_head.len == '0) : (beat_cnt == hdr_q.len);

    always_comb begin
        mem.id   = cur_hdr.id;
        mem.addr = (phase == PH_FIRST) ? first_addr : beat_addr;
        mem.data = w_head.data;
        mem.strb = w_head.strb;
        mem.last = last_beat;
    end

    // Response, same cycle as the last beat or later from BRESP
    assign b_push     = !b_full && ((beat_ok && last_beat) || (phase == PH_BRESP));
    assign b_din.id   = cur_hdr.id;
    assign b_din.resp = (cur_hdr.size > MAX_SIZE) ? RESP_SLVERR : RESP_OKAY;

    burst_addr_gen u_addr_gen (
        .hdr        (cur_hdr),
        .cur_addr   ((phase == PH_FIRST) ? aw_head.addr : beat_addr),
        .first_addr (first_addr),
        .next_addr  (next_addr)
    );

    // ------------------------------------------------------------------
    // Phase FSM
    // ------------------------------------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE:  phase_nxt = PH_FIRST;
            PH_FIRST, PH_BURST: begin
                if (beat_ok) begin
                    if (!last_beat) begin
                        phase_nxt = PH_BURST;
                    end else begin
                        phase_nxt = b_full ? PH_BRESP : PH_FIRST;
                    end
                end
            end
            PH_BRESP: phase_nxt = b_full ? PH_BRESP : PH_FIRST;
            default:  phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            beat_cnt  <= '0;
            beat_addr <= '0;
        end else begin
            phase <= phase_nxt;
            // Counter and address move only on granted beats
            if (beat_ok) begin
                beat_cnt  <= (phase == PH_FIRST) ? LEN_W'(1) : beat_cnt + 1'b1;
                beat_addr <= next_addr;
            end
        end
    end

    // Header copy for the rest of the burst
    always_ff @(posedge clk) begin
        if (aw_pop) begin
            hdr_q <= aw_head;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench, judge the run from sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_slave_wr \
    -f compile.f -Mdir obj_dir > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_axi_slave_wr > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || { echo "no pass message found in sim.log"; exit 1; }
exit 0

//--- test/axi_slave_wr_properties.sv
// Protocol assertions on the write slave ports, bound into the top level
// AW ready tracking, grant before write, B hold and reset state

`timescale 1ns/1ps
`default_nettype none

module axi_slave_wr_properties (
    input logic clk,
    input logic rst_n,
    input logic aw_ready,
    input logic aw_full,
    input logic b_valid,
    input logic b_ready,
    input logic wr_grant,
    input logic wr_request,
    input logic mem_we
);

    // AW ready is the inverse of the AW buffer full flag
    property aw_ready_tracks_full;
        @(posedge clk) disable iff (!rst_n) aw_ready == !aw_full;
    endproperty

    // A memory write needs the arbiter grant in the same cycle
    property write_needs_grant;
        @(posedge clk) disable iff (!rst_n) mem_we |-> wr_grant;
    endproperty

    // Pending response held until accepted
    property b_valid_held;
        @(posedge clk) disable iff (!rst_n) (b_valid && !b_ready) |=> b_valid;
    endproperty

    // Control outputs quiet while reset is applied
    property quiet_in_reset;
        @(posedge clk) !rst_n |-> (!b_valid && !mem_we && !wr_request);
    endproperty

    a_aw_ready: assert property (aw_ready_tracks_full)
        else $error("aw_ready differs from the inverse of the AW buffer full flag");
    a_grant: assert property (write_needs_grant)
        else $error("mem_we high without wr_grant");
    a_b_hold: assert property (b_valid_held)
        else $error("b_valid dropped before b_ready");
    a_reset: assert property (quiet_in_reset)
        else $error("control output high during reset");

endmodule

bind axi_slave_wr axi_slave_wr_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .aw_ready   (aw_ready),
    .aw_full    (aw_full),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .wr_grant   (wr_grant),
    .wr_request (wr_request),
    .mem_we     (mem_we)
);

`default_nettype wire

//--- test/tb_axi_slave_wr.sv
// AXI4 write slave testbench with clock, reset, directed and random bursts
// Reference queues of expected beats and responses checked by assertions
// Watchdog limit scales with the number of bursts sent

`timescale 1ns/1ps
`default_nettype none

module tb_axi_slave_wr;

    import axi_wr_pkg::*;

    localparam logic [31:0] SEED         = 32'h46df_9614;
    localparam int          NUM_DIRECTED = 5;
    localparam int          NUM_RANDOM   = 40;
    localparam int          NUM_BURSTS   = NUM_DIRECTED + NUM_RANDOM;
    localparam int          BURST_CYCLES = 200;
    localparam int          BEAT_CAP     = 1024;
    localparam int          RESP_CAP     = 64;

    logic    clk;
    logic    rst_n;
    aw_req_t aw;
    logic    aw_valid;
    logic    aw_ready;
    w_beat_t w;
    logic    w_valid;
    logic    w_ready;
    b_resp_t b;
    logic    b_valid;
    logic    b_ready;
    logic    wr_grant;
    logic    wr_request;
    logic    mem_we;
    mem_wr_t mem;

    // Grant and b_ready follow the random stream once this is set
    logic        random_ctl;
    logic [31:0] stim_rng;

    // Reference queues written at send time and read in arrival order
    mem_wr_t     exp_beats [BEAT_CAP];
    b_resp_t     exp_resps [RESP_CAP];
    logic [9:0]  beat_wr = '0;
    logic [9:0]  beat_rd = '0;
    logic [5:0]  resp_wr = '0;
    logic [5:0]  resp_rd = '0;
    mem_wr_t     exp_beat;
    b_resp_t     exp_resp;

    int          mismatch_count = 0;
    int          other_count    = 0;

    assign exp_beat = exp_beats[beat_rd];
    assign exp_resp = exp_resps[resp_rd];

    axi_slave_wr uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .wr_grant   (wr_grant),
        .wr_request (wr_request),
        .mem_we     (mem_we),
        .mem        (mem)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic aw_req_t build_hdr(input logic [3:0] id, input logic [31:0] addr,
                                          input logic [7:0] len, input logic [2:0] size,
                                          input logic [1:0] burst);
        aw_req_t h;
        h.id    = id;
        h.addr  = addr;
        h.len   = len;
        h.size  = size;
        h.burst = burst;
        return h;
    endfunction

    // Records the expected beats and response and then drives AW and W
    task automatic send_burst(input aw_req_t hdr);
        logic [ADDR_W-1:0] beat_addr;
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] step;
        logic [ADDR_W-1:0] inc;
        logic [2:0]        eff_size;
        w_beat_t           wb;
        mem_wr_t           eb;
        b_resp_t           er;
        int                i;
        // Beats wider than the data bus get SLVERR
        er.id   = hdr.id;
        er.resp = ((32'd1 << hdr.size) > STRB_W) ? RESP_SLVERR : RESP_OKAY;
        exp_resps[resp_wr] = er;
        resp_wr = resp_wr + 1'b1;
        // Oversized transfers still step as full words
        eff_size  = (hdr.size > MAX_SIZE) ? MAX_SIZE : hdr.size;
        inc       = (hdr.burst == BURST_FIXED) ? '0 : (32'd1 << eff_size);
        beat_addr = hdr.addr;
        // aw_ready comes from registered state and holds until the next edge
        aw       = hdr;
        aw_valid = 1'b1;
        while (!aw_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        aw_valid = 1'b0;
        for (i = 0; i <= int'(hdr.len); i++) begin
            stim_rng = xorshift32(stim_rng);
            wb.data  = stim_rng;
            wb.strb  = stim_rng[7:4];
            wb.last  = (i == int'(hdr.len));
            eb.id    = hdr.id;
            eb.addr  = beat_addr;
            eb.data  = wb.data;
            eb.strb  = wb.strb;
            eb.last  = wb.last;
            exp_beats[beat_wr] = eb;
            beat_wr = beat_wr + 1'b1;
            // Next beat steps from the aligned address and holds if it leaves the 4 KB page
            base      = beat_addr & ~((32'd1 << eff_size) - 32'd1);
            step      = base + inc;
            beat_addr = ((step >> 12) == (base >> 12)) ? step : base;
            w       = wb;
            w_valid = 1'b1;
            while (!w_ready) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
        end
        w_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Checks on the memory port and the B channel
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n && mem_we) beat_rd <= beat_rd + 1'b1;
        if (rst_n && b_valid && b_ready) resp_rd <= resp_rd + 1'b1;
    end

    a_beat_pending: assert property (@(posedge clk) disable iff (!rst_n)
                                     mem_we |-> (beat_rd != beat_wr))
        else begin
            other_count = other_count + 1;
            $display("%0t: memory write seen while no beat was expected", $time);
        end

    a_beat_value: assert property (@(posedge clk) disable iff (!rst_n)
                                   mem_we |-> (mem == exp_beat))
        else begin
            mismatch_count = mismatch_count + 1;
            $display("mismatch at %0t: mem expected %h seen %h", $time,
                     $sampled(exp_beat), $sampled(mem));
        end

    // The request stays up while the arbiter holds back the grant
    a_request_held: assert property (@(posedge clk) disable iff (!rst_n)
                                     (wr_request && !wr_grant) |=> wr_request)
        else begin
            other_count = other_count + 1;
            $display("%0t: wr_request dropped while waiting for wr_grant", $time);
        end

    a_resp_pending: assert property (@(posedge clk) disable iff (!rst_n)
                                     (b_valid && b_ready) |-> (resp_rd != resp_wr))
        else begin
            other_count = other_count + 1;
            $display("%0t: B response seen while no response was expected", $time);
        end

    a_resp_value: assert property (@(posedge clk) disable iff (!rst_n)
                                   (b_valid && b_ready) |-> (b == exp_resp))
        else begin
            mismatch_count = mismatch_count + 1;
            $display("mismatch at %0t: b expected %h seen %h", $time,
                     $sampled(exp_resp), $sampled(b));
        end

    // ------------------------------------------------------------------
    // Arbiter grant and B back-pressure
    // ------------------------------------------------------------------
    initial begin : grant_bready_drive
        logic [31:0] r;
        r        = SEED ^ 32'h5a5a_5a5a;
        wr_grant = 1'b0;
        b_ready  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (random_ctl) begin
                r = xorshift32(r);
                // Grant in about 3 of 4 cycles and b_ready in 1 of 4 so B fills up
                wr_grant = (r[3:2] != 2'b00);
                b_ready  = (r[1:0] == 2'b00);
            end else begin
                wr_grant = 1'b1;
                b_ready  = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_BURSTS * BURST_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", NUM_BURSTS * BURST_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin : stimulus
        aw_req_t     hdr;
        logic [31:0] r;
        logic [31:0] r2;
        int          n;
        rst_n      = 1'b1;
        aw         = '0;
        aw_valid   = 1'b0;
        w          = '0;
        w_valid    = 1'b0;
        random_ctl = 1'b0;
        stim_rng   = SEED;
        #1;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        // Directed single beat, unaligned INCR, FIXED, oversize and page edge bursts
        send_burst(build_hdr(4'h1, 32'h0000_0100, 8'd0, 3'd2, BURST_INCR));
        send_burst(build_hdr(4'h2, 32'h0000_0203, 8'd3, 3'd2, BURST_INCR));
        send_burst(build_hdr(4'h3, 32'h0000_0300, 8'd3, 3'd2, BURST_FIXED));
        send_burst(build_hdr(4'h4, 32'h0000_0400, 8'd2, 3'd3, BURST_INCR));
        send_burst(build_hdr(4'h5, 32'h0000_1ff8, 8'd4, 3'd2, BURST_INCR));
        // Back-to-back random bursts under random grant and b_ready
        random_ctl = 1'b1;
        for (n = 0; n < NUM_RANDOM; n++) begin
            stim_rng = xorshift32(stim_rng);
            r        = stim_rng;
            stim_rng = xorshift32(stim_rng);
            r2       = stim_rng;
            hdr = build_hdr(r[3:0], {18'd0, r2[13:0]}, {5'd0, r[6:4]}, {1'b0, r[9:8]},
                            r[11:10]);
            // Some bursts start in the last 32 bytes of a page
            if (r[12]) hdr.addr[11:5] = 7'h7f;
            send_burst(hdr);
        end
        while ((beat_rd != beat_wr) || (resp_rd != resp_wr)) begin
            @(posedge clk);
            #1;
        end
        // Idle tail catches duplicated beats or responses
        repeat (20) @(posedge clk);
        $display("checked %0d beats and %0d responses, %0d mismatches, %0d other errors",
                 beat_rd, resp_rd, mismatch_count, other_count);
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
